/* cache_pkg.sv */
// Shared sizes and types for the L1 data cache tag unit.
// A line address holds the set index in its low bits and the tag above it.
// Only the four-way case is supported by the LRU tree and the hit encoder.
package cache_pkg;

	// Cache geometry
	localparam int L1_NUM_WAYS = 4;
	localparam int L1_NUM_SETS = 16;
	localparam int L1_SET_INDEX_WIDTH = 4;
	localparam int L1_ADDR_WIDTH = 26;

	// The tag is whatever remains of the line address above the set index
	localparam int L1_TAG_WIDTH = L1_ADDR_WIDTH - L1_SET_INDEX_WIDTH;

	// Line address, with bits [3:0] selecting the set
	typedef logic [L1_ADDR_WIDTH - 1:0] l1_addr_t;
	typedef logic [L1_TAG_WIDTH - 1:0] l1_tag_t;
	typedef logic [L1_SET_INDEX_WIDTH - 1:0] l1_set_t;
	typedef logic [$clog2(L1_NUM_WAYS) - 1:0] l1_way_t;
	typedef logic [L1_NUM_WAYS - 1:0] l1_way_mask_t;

	// Tree pseudo-LRU bits for one set
	// Bit 0 is the root and selects the pair holding the victim (0 is ways 0-1)
	// Bit 1 selects within ways 0-1 and bit 2 within ways 2-3
	typedef logic [2:0] l1_lru_bits_t;

	// The controller is either free or in the second cycle of an invalidate
	typedef enum logic
	{
		CTRL_IDLE,
		CTRL_INVAL_PROBE
	} tag_ctrl_state_t;

endpackage

/* sram_1r1w.sv */
// Simple dual-port RAM with one read and one write port.
// The read is registered and only updates while rd_enable_i is high.
// A read of the address being written in the same cycle returns the old data.
`timescale 1ns/1ns

module sram_1r1w
	#(parameter DATA_WIDTH = 32,
	parameter SIZE = 64)
	(input                             clk,
	input                              rd_enable_i,
	input [$clog2(SIZE) - 1:0]         rd_addr_i,
	output logic [DATA_WIDTH - 1:0]    rd_data_o,
	input                              wr_enable_i,
	input [$clog2(SIZE) - 1:0]         wr_addr_i,
	input [DATA_WIDTH - 1:0]           wr_data_i);

	// Storage array, contents are undefined until written
	logic [DATA_WIDTH - 1:0] mem [SIZE];

	always_ff @(posedge clk)
	begin
		// Both sides use nonblocking updates, so a read at the same
		// address sees the value from before this edge
		if (wr_enable_i)
			mem[wr_addr_i] <= wr_data_i;

		if (rd_enable_i)
			rd_data_o <= mem[rd_addr_i];
	end

endmodule

/* cache_valid_array.sv */
// Valid bits for one way, one bit per set, held in flops.
// Reset clears every bit, so all lines start out invalid.
// The read is registered like the tag RAM beside it.
`timescale 1ns/1ns

module cache_valid_array
	#(parameter NUM_SETS = 32)
	(input                             clk,
	input                              reset,
	input                              rd_enable_i,
	input [$clog2(NUM_SETS) - 1:0]     rd_addr_i,
	output logic                       rd_valid_o,
	input                              wr_enable_i,
	input [$clog2(NUM_SETS) - 1:0]     wr_addr_i,
	input                              wr_valid_i);

	logic [NUM_SETS - 1:0] valid_bits;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			valid_bits <= '0;
			rd_valid_o <= 1'b0;
		end
		else
		begin
			// Write lands at the edge; a read in the same cycle sees the old bit
			if (wr_enable_i)
				valid_bits[wr_addr_i] <= wr_valid_i;

			// Hold the last read result when no lookup is issued
			if (rd_enable_i)
				rd_valid_o <= valid_bits[rd_addr_i];
		end
	end

endmodule

/* l1_cache_tag.sv */
// Tag and valid storage for the four-way L1 data cache.
// The set index goes to all ways in parallel and the hit result comes back
// one cycle later. Assumes at most one way can match a given tag.
// valid_set_o is a combinational read of a flop copy of the valid bits.
`timescale 1ns/1ns

module l1_cache_tag
	(input                             clk,
	input                              reset,

	// Lookup side
	input                              lookup_access_i,
	input cache_pkg::l1_addr_t         lookup_addr_i,

	// Update side, driven by the controller
	input                              tag_update_i,
	input                              tag_inval_one_i,
	input                              tag_inval_all_i,
	input cache_pkg::l1_way_t          update_way_i,
	input cache_pkg::l1_tag_t          update_tag_i,
	input cache_pkg::l1_set_t          update_set_i,

	// Results
	output logic                       tag_hit_o,
	output cache_pkg::l1_way_t         tag_hit_way_o,
	output cache_pkg::l1_way_mask_t    valid_set_o);

	cache_pkg::l1_set_t lookup_set;
	cache_pkg::l1_tag_t lookup_tag;
	cache_pkg::l1_tag_t lookup_tag_latched;
	logic access_latched;
	cache_pkg::l1_tag_t way_tag [cache_pkg::L1_NUM_WAYS];
	cache_pkg::l1_way_mask_t way_valid;
	cache_pkg::l1_way_mask_t way_write;
	cache_pkg::l1_way_mask_t tag_write;
	cache_pkg::l1_way_mask_t hit_oh;
	cache_pkg::l1_way_mask_t valid_copy [cache_pkg::L1_NUM_SETS];

	// Split the line address into set index and tag
	assign lookup_set = lookup_addr_i[cache_pkg::L1_SET_INDEX_WIDTH - 1:0];
	assign lookup_tag = lookup_addr_i[cache_pkg::L1_ADDR_WIDTH - 1:cache_pkg::L1_SET_INDEX_WIDTH];

	genvar way;
	generate
		for (way = 0; way < cache_pkg::L1_NUM_WAYS; way++)
		begin : gen_way
			// Valid bit changes on a fill or invalidate of this way, or on a flush
			assign way_write[way] = ((tag_update_i || tag_inval_one_i)
				&& update_way_i == cache_pkg::l1_way_t'(way)) || tag_inval_all_i;

			// The tag itself only needs writing when a line is installed
			assign tag_write[way] = tag_update_i && update_way_i == cache_pkg::l1_way_t'(way);

			sram_1r1w #(
				.DATA_WIDTH(cache_pkg::L1_TAG_WIDTH),
				.SIZE(cache_pkg::L1_NUM_SETS)) tag_mem (
				.clk(clk),
				.rd_enable_i(lookup_access_i),
				.rd_addr_i(lookup_set),
				.rd_data_o(way_tag[way]),
				.wr_enable_i(tag_write[way]),
				.wr_addr_i(update_set_i),
				.wr_data_i(update_tag_i));

			cache_valid_array #(.NUM_SETS(cache_pkg::L1_NUM_SETS)) valid_mem (
				.clk(clk),
				.reset(reset),
				.rd_enable_i(lookup_access_i),
				.rd_addr_i(lookup_set),
				.rd_valid_o(way_valid[way]),
				.wr_enable_i(way_write[way]),
				.wr_addr_i(update_set_i),
				.wr_valid_i(tag_update_i));

			// Compare in the cycle after the request, against the latched tag
			assign hit_oh[way] = way_valid[way] && way_tag[way] == lookup_tag_latched;
		end
	endgenerate

	// Request tag travels alongside the RAM read
	always_ff @(posedge clk)
	begin
		if (lookup_access_i)
			lookup_tag_latched <= lookup_tag;
	end

	// Access flag and the victim-select copy of the valid bits
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			access_latched <= 1'b0;
			for (int s = 0; s < cache_pkg::L1_NUM_SETS; s++)
				valid_copy[s] <= '0;
		end
		else
		begin
			access_latched <= lookup_access_i;
			for (int w = 0; w < cache_pkg::L1_NUM_WAYS; w++)
			begin
				if (way_write[w])
					valid_copy[update_set_i][w] <= tag_update_i;
			end
		end
	end

	assign valid_set_o = valid_copy[update_set_i];

	// One-hot match to way number
	always_comb
	begin
		tag_hit_way_o = '0;
		for (int w = 0; w < cache_pkg::L1_NUM_WAYS; w++)
		begin
			if (hit_oh[w])
				tag_hit_way_o = cache_pkg::l1_way_t'(w);
		end
	end

	assign tag_hit_o = access_latched && |hit_oh;

endmodule

/* cache_lru.sv */
// Tree pseudo-LRU for the four-way cache, one 3-bit tree per set.
// The victim for victim_set_i is available combinationally.
// A touch makes the tree point away from the touched way.
`timescale 1ns/1ns

module cache_lru
	(input                             clk,
	input                              reset,
	input cache_pkg::l1_set_t          victim_set_i,
	output cache_pkg::l1_way_t         victim_way_o,
	input                              touch_i,
	input cache_pkg::l1_set_t          touch_set_i,
	input cache_pkg::l1_way_t          touch_way_i);

	cache_pkg::l1_lru_bits_t tree [cache_pkg::L1_NUM_SETS];
	cache_pkg::l1_lru_bits_t victim_bits;

	assign victim_bits = tree[victim_set_i];

	// Root picks the pair, then the pair's own bit picks the way
	always_comb
	begin
		if (victim_bits[0])
			victim_way_o = {1'b1, victim_bits[2]};
		else
			victim_way_o = {1'b0, victim_bits[1]};
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int s = 0; s < cache_pkg::L1_NUM_SETS; s++)
				tree[s] <= '0;
		end
		else if (touch_i)
		begin
			// Root points to the other pair
			tree[touch_set_i][0] <= !touch_way_i[1];

			// Pair bit points to the sibling of the touched way,
			// the other pair's bit is left alone
			if (touch_way_i[1])
				tree[touch_set_i][2] <= !touch_way_i[0];
			else
				tree[touch_set_i][1] <= !touch_way_i[0];
		end
	end

endmodule

/* cache_tag_ctrl.sv */
// Request controller for the L1 tag unit.
// Callers raise at most one strobe per cycle and stay idle while busy_o is high.
// Invalidates take two cycles, a probe lookup then a conditional clear.
`timescale 1ns/1ns

module cache_tag_ctrl
	(input                             clk,
	input                              reset,

	// Outside requests
	input                              access_i,
	input cache_pkg::l1_addr_t         request_addr_i,
	input                              fill_i,
	input cache_pkg::l1_addr_t         fill_addr_i,
	input                              invalidate_i,
	input cache_pkg::l1_addr_t         invalidate_addr_i,
	input                              flush_i,
	input cache_pkg::l1_set_t          flush_set_i,

	// Outside responses
	output logic                       response_valid_o,
	output logic                       cache_hit_o,
	output cache_pkg::l1_way_t         hit_way_o,
	output logic                       busy_o,

	// Tag block
	output logic                       lookup_access_o,
	output cache_pkg::l1_addr_t        lookup_addr_o,
	output logic                       tag_update_o,
	output logic                       tag_inval_one_o,
	output logic                       tag_inval_all_o,
	output cache_pkg::l1_way_t         update_way_o,
	output cache_pkg::l1_tag_t         update_tag_o,
	output cache_pkg::l1_set_t         update_set_o,
	input                              tag_hit_i,
	input cache_pkg::l1_way_t          tag_hit_way_i,
	input cache_pkg::l1_way_mask_t     valid_set_i,

	// LRU
	input cache_pkg::l1_way_t          lru_victim_way_i,
	output logic                       lru_touch_o,
	output cache_pkg::l1_set_t         lru_touch_set_o,
	output cache_pkg::l1_way_t         lru_touch_way_o);

	cache_pkg::tag_ctrl_state_t state;
	cache_pkg::tag_ctrl_state_t state_nxt;
	logic ext_pending;
	cache_pkg::l1_set_t pending_set;
	cache_pkg::l1_way_t free_way;
	cache_pkg::l1_way_t fill_way;
	logic ext_hit;
	logic probe_hit;

	// Probe reuses the lookup port; only one of the two strobes is ever high
	assign lookup_access_o = access_i || invalidate_i;
	assign lookup_addr_o = invalidate_i ? invalidate_addr_i : request_addr_i;

	always_comb
	begin
		state_nxt = state;
		case (state)
			cache_pkg::CTRL_IDLE:
				if (invalidate_i)
					state_nxt = cache_pkg::CTRL_INVAL_PROBE;

			// Always one cycle, the probe result is acted on right here
			default:
				state_nxt = cache_pkg::CTRL_IDLE;
		endcase
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= cache_pkg::CTRL_IDLE;
			ext_pending <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			ext_pending <= access_i;
		end
	end

	// Set of the outstanding read, used for the hit touch and the probe clear
	always_ff @(posedge clk)
	begin
		if (lookup_access_o)
			pending_set <= lookup_addr_o[cache_pkg::L1_SET_INDEX_WIDTH - 1:0];
	end

	assign busy_o = state == cache_pkg::CTRL_INVAL_PROBE;
	assign ext_hit = ext_pending && tag_hit_i;
	assign probe_hit = busy_o && tag_hit_i;

	// Only external lookups produce a response
	assign response_valid_o = ext_pending;
	assign cache_hit_o = ext_hit;
	assign hit_way_o = tag_hit_way_i;

	// Lowest-numbered invalid way of the fill set
	always_comb
	begin
		free_way = '0;
		for (int w = cache_pkg::L1_NUM_WAYS - 1; w >= 0; w--)
		begin
			if (!valid_set_i[w])
				free_way = cache_pkg::l1_way_t'(w);
		end
	end

	// Empty ways go first, otherwise evict what the tree names
	assign fill_way = &valid_set_i ? lru_victim_way_i : free_way;

	// Write side; the probe cycle never overlaps a fill or flush
	assign tag_update_o = fill_i;
	assign tag_inval_all_o = flush_i;
	assign tag_inval_one_o = probe_hit;
	assign update_tag_o = fill_addr_i[cache_pkg::L1_ADDR_WIDTH - 1:cache_pkg::L1_SET_INDEX_WIDTH];
	assign update_way_o = fill_i ? fill_way : tag_hit_way_i;

	always_comb
	begin
		if (fill_i)
			update_set_o = fill_addr_i[cache_pkg::L1_SET_INDEX_WIDTH - 1:0];
		else if (flush_i)
			update_set_o = flush_set_i;
		else
			update_set_o = pending_set;
	end

	// A fill touch wins over a hit touch arriving in the same cycle
	assign lru_touch_o = fill_i || ext_hit;
	assign lru_touch_set_o = fill_i ? fill_addr_i[cache_pkg::L1_SET_INDEX_WIDTH - 1:0]
		: pending_set;
	assign lru_touch_way_o = fill_i ? fill_way : tag_hit_way_i;

endmodule

/* l1_tag_unit.sv */
// Top of the L1 data cache tag unit: controller, tag storage and LRU.
// Lookups answer one cycle after access_i; invalidates hold busy_o for a cycle.
`timescale 1ns/1ns

module l1_tag_unit
	(input                             clk,
	input                              reset,
	input                              access_i,
	input cache_pkg::l1_addr_t         request_addr_i,
	input                              fill_i,
	input cache_pkg::l1_addr_t         fill_addr_i,
	input                              invalidate_i,
	input cache_pkg::l1_addr_t         invalidate_addr_i,
	input                              flush_i,
	input cache_pkg::l1_set_t          flush_set_i,
	output logic                       response_valid_o,
	output logic                       cache_hit_o,
	output cache_pkg::l1_way_t         hit_way_o,
	output logic                       busy_o);

	logic lookup_access;
	cache_pkg::l1_addr_t lookup_addr;
	logic tag_update;
	logic tag_inval_one;
	logic tag_inval_all;
	cache_pkg::l1_way_t update_way;
	cache_pkg::l1_tag_t update_tag;
	cache_pkg::l1_set_t update_set;
	logic tag_hit;
	cache_pkg::l1_way_t tag_hit_way;
	cache_pkg::l1_way_mask_t valid_set;
	cache_pkg::l1_way_t lru_victim_way;
	logic lru_touch;
	cache_pkg::l1_set_t lru_touch_set;
	cache_pkg::l1_way_t lru_touch_way;

	cache_tag_ctrl ctrl (
		.clk(clk),
		.reset(reset),
		.access_i(access_i),
		.request_addr_i(request_addr_i),
		.fill_i(fill_i),
		.fill_addr_i(fill_addr_i),
		.invalidate_i(invalidate_i),
		.invalidate_addr_i(invalidate_addr_i),
		.flush_i(flush_i),
		.flush_set_i(flush_set_i),
		.response_valid_o(response_valid_o),
		.cache_hit_o(cache_hit_o),
		.hit_way_o(hit_way_o),
		.busy_o(busy_o),
		.lookup_access_o(lookup_access),
		.lookup_addr_o(lookup_addr),
		.tag_update_o(tag_update),
		.tag_inval_one_o(tag_inval_one),
		.tag_inval_all_o(tag_inval_all),
		.update_way_o(update_way),
		.update_tag_o(update_tag),
		.update_set_o(update_set),
		.tag_hit_i(tag_hit),
		.tag_hit_way_i(tag_hit_way),
		.valid_set_i(valid_set),
		.lru_victim_way_i(lru_victim_way),
		.lru_touch_o(lru_touch),
		.lru_touch_set_o(lru_touch_set),
		.lru_touch_way_o(lru_touch_way));

	l1_cache_tag tag (
		.clk(clk),
		.reset(reset),
		.lookup_access_i(lookup_access),
		.lookup_addr_i(lookup_addr),
		.tag_update_i(tag_update),
		.tag_inval_one_i(tag_inval_one),
		.tag_inval_all_i(tag_inval_all),
		.update_way_i(update_way),
		.update_tag_i(update_tag),
		.update_set_i(update_set),
		.tag_hit_o(tag_hit),
		.tag_hit_way_o(tag_hit_way),
		.valid_set_o(valid_set));

	// Victim is looked up for the set of the incoming fill
	cache_lru lru (
		.clk(clk),
		.reset(reset),
		.victim_set_i(fill_addr_i[cache_pkg::L1_SET_INDEX_WIDTH - 1:0]),
		.victim_way_o(lru_victim_way),
		.touch_i(lru_touch),
		.touch_set_i(lru_touch_set),
		.touch_way_i(lru_touch_way));

endmodule

/* tb_l1_tag_unit.sv */
// Testbench for the L1 tag unit, checked against a cycle-level reference model.
// Drives at most one strobe per cycle and keeps the ports idle while busy_o is high.
// Random fills only install absent addresses, since a set never holds one tag twice.
`timescale 1ns/1ns

module tb_l1_tag_unit;

	logic clk;
	logic reset;
	logic access_i;
	cache_pkg::l1_addr_t request_addr_i;
	logic fill_i;
	cache_pkg::l1_addr_t fill_addr_i;
	logic invalidate_i;
	cache_pkg::l1_addr_t invalidate_addr_i;
	logic flush_i;
	cache_pkg::l1_set_t flush_set_i;
	logic response_valid_o;
	logic cache_hit_o;
	cache_pkg::l1_way_t hit_way_o;
	logic busy_o;

	// Reference model state, written at the same edges as the DUT
	logic model_valid [cache_pkg::L1_NUM_SETS][cache_pkg::L1_NUM_WAYS];
	cache_pkg::l1_tag_t model_tag [cache_pkg::L1_NUM_SETS][cache_pkg::L1_NUM_WAYS];
	cache_pkg::l1_lru_bits_t model_lru [cache_pkg::L1_NUM_SETS];

	// What the read issued in the previous cycle should produce in this one
	logic exp_valid;
	logic exp_hit;
	logic exp_busy;
	logic probe_hit;
	cache_pkg::l1_way_t exp_way;
	cache_pkg::l1_set_t exp_set;

	int seed = 29078;
	int directed_cycles = 64;
	int random_cycles = 300;
	int pick;
	cache_pkg::l1_addr_t rand_addr;

	l1_tag_unit uut (
		.clk(clk),
		.reset(reset),
		.access_i(access_i),
		.request_addr_i(request_addr_i),
		.fill_i(fill_i),
		.fill_addr_i(fill_addr_i),
		.invalidate_i(invalidate_i),
		.invalidate_addr_i(invalidate_addr_i),
		.flush_i(flush_i),
		.flush_set_i(flush_set_i),
		.response_valid_o(response_valid_o),
		.cache_hit_o(cache_hit_o),
		.hit_way_o(hit_way_o),
		.busy_o(busy_o));

	initial
	begin
		clk = 1'b0;
		forever #10 clk = !clk;
	end

	// Every invalidate costs two cycles, so the random phase may double in length
	initial
	begin
		#(40 * (directed_cycles + 2 * random_cycles) * 20);
		$display("Timeout: the test sequence did not finish in the expected time");
		stop_on_failure();
	end

	task automatic stop_on_failure();
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] expected);
		$display("FAILED %s: got %h, expected %h", name, got, expected);
		stop_on_failure();
	endtask

	function automatic cache_pkg::l1_set_t set_of(cache_pkg::l1_addr_t a);
		return a[cache_pkg::L1_SET_INDEX_WIDTH - 1:0];
	endfunction

	function automatic cache_pkg::l1_tag_t tag_of(cache_pkg::l1_addr_t a);
		return a[cache_pkg::L1_ADDR_WIDTH - 1:cache_pkg::L1_SET_INDEX_WIDTH];
	endfunction

	function automatic cache_pkg::l1_addr_t line_addr(int t, int s);
		return {cache_pkg::l1_tag_t'(t), cache_pkg::l1_set_t'(s)};
	endfunction

	// Small tag and set ranges so that hits and evictions are common
	function automatic cache_pkg::l1_addr_t random_addr();
		int t;
		int s;
		t = int'($unsigned($random(seed)) % 6);
		s = int'($unsigned($random(seed)) % 4);
		return line_addr(t, s);
	endfunction

	// Way holding the address in the model, or -1 when it is absent
	function automatic int find_way(cache_pkg::l1_addr_t a);
		int found;
		found = -1;
		for (int w = 0; w < cache_pkg::L1_NUM_WAYS; w++)
		begin
			if (model_valid[set_of(a)][w] && model_tag[set_of(a)][w] == tag_of(a))
				found = w;
		end
		return found;
	endfunction

	// Way named by the tree bits of one set
	function automatic int victim_of(cache_pkg::l1_lru_bits_t bits);
		if (bits[0])
			return bits[2] ? 3 : 2;
		return bits[1] ? 1 : 0;
	endfunction

	// Tree bits end up pointing at the other pair and at the touched way's sibling
	task automatic touch_model(cache_pkg::l1_set_t s, int w);
		case (w)
			0: model_lru[s] = {model_lru[s][2], 1'b1, 1'b1};
			1: model_lru[s] = {model_lru[s][2], 1'b0, 1'b1};
			2: model_lru[s] = {1'b1, model_lru[s][1], 1'b0};
			default: model_lru[s] = {1'b0, model_lru[s][1], 1'b0};
		endcase
	endtask

	task automatic check_outputs();
		assert (response_valid_o === exp_valid)
		else
			report_mismatch("response_valid_o", 32'(response_valid_o), 32'(exp_valid));
		assert (busy_o === exp_busy)
		else
			report_mismatch("busy_o", 32'(busy_o), 32'(exp_busy));
		assert (cache_hit_o === (exp_valid && exp_hit))
		else
			report_mismatch("cache_hit_o", 32'(cache_hit_o), 32'(exp_valid && exp_hit));
		if (exp_valid && exp_hit)
		begin
			assert (hit_way_o === exp_way)
			else
				report_mismatch("hit_way_o", 32'(hit_way_o), 32'(exp_way));
		end
	endtask

	// Applies everything that happens at the coming edge, reads before writes
	task automatic update_model();
		int lk;
		int fw;
		cache_pkg::l1_set_t s;
		lk = -1;
		if (access_i)
			lk = find_way(request_addr_i);
		else if (invalidate_i)
			lk = find_way(invalidate_addr_i);

		// A fill in the response cycle takes the LRU port and the hit touch is lost
		if (exp_valid && exp_hit && !fill_i)
			touch_model(exp_set, int'(exp_way));

		// Second cycle of an invalidate clears the way the probe found
		if (exp_busy && probe_hit)
			model_valid[exp_set][exp_way] = 1'b0;

		if (fill_i)
		begin
			s = set_of(fill_addr_i);

			// The first empty way from way 0 upward, else the tree's choice
			fw = -1;
			for (int w = 0; w < cache_pkg::L1_NUM_WAYS; w++)
			begin
				if (fw < 0 && !model_valid[s][w])
					fw = w;
			end
			if (fw < 0)
				fw = victim_of(model_lru[s]);
			model_valid[s][fw] = 1'b1;
			model_tag[s][fw] = tag_of(fill_addr_i);
			touch_model(s, fw);
		end

		if (flush_i)
		begin
			for (int w = 0; w < cache_pkg::L1_NUM_WAYS; w++)
				model_valid[flush_set_i][w] = 1'b0;
		end

		exp_valid = access_i;
		exp_hit = access_i && lk >= 0;
		exp_busy = invalidate_i;
		probe_hit = invalidate_i && lk >= 0;
		exp_way = cache_pkg::l1_way_t'(lk);
		if (access_i || invalidate_i)
			exp_set = set_of(access_i ? request_addr_i : invalidate_addr_i);
	endtask

	// Outputs are checked mid-cycle, then strobes drop 2 ns after the edge
	task automatic run_cycle();
		@(negedge clk);
		check_outputs();
		update_model();
		@(posedge clk);
		#2;
		access_i = 1'b0;
		fill_i = 1'b0;
		invalidate_i = 1'b0;
		flush_i = 1'b0;
	endtask

	task automatic idle_cycle();
		run_cycle();
	endtask

	task automatic send_lookup(cache_pkg::l1_addr_t a);
		access_i = 1'b1;
		request_addr_i = a;
		run_cycle();
	endtask

	task automatic install_line(cache_pkg::l1_addr_t a);
		fill_i = 1'b1;
		fill_addr_i = a;
		run_cycle();
	endtask

	// Probe cycle plus the busy cycle in which the ports stay idle
	task automatic invalidate_line(cache_pkg::l1_addr_t a);
		invalidate_i = 1'b1;
		invalidate_addr_i = a;
		run_cycle();
		idle_cycle();
	endtask

	task automatic flush_one_set(cache_pkg::l1_set_t s);
		flush_i = 1'b1;
		flush_set_i = s;
		run_cycle();
	endtask

	// Holds the reference model to the directed scenario
	// The DUT itself is compared with the model in the next cycle
	task automatic lookup_expect(cache_pkg::l1_addr_t a, logic hit);
		send_lookup(a);
		assert (exp_hit === hit)
		else
		begin
			$display("Reference model disagrees with the directed scenario for address %h", a);
			stop_on_failure();
		end
	endtask

	initial
	begin
		reset = 1'b1;
		access_i = 1'b0;
		fill_i = 1'b0;
		invalidate_i = 1'b0;
		flush_i = 1'b0;
		request_addr_i = '0;
		fill_addr_i = '0;
		invalidate_addr_i = '0;
		flush_set_i = '0;
		exp_valid = 1'b0;
		exp_hit = 1'b0;
		exp_busy = 1'b0;
		probe_hit = 1'b0;
		exp_way = '0;
		exp_set = '0;
		for (int s = 0; s < cache_pkg::L1_NUM_SETS; s++)
		begin
			model_lru[s] = '0;
			for (int w = 0; w < cache_pkg::L1_NUM_WAYS; w++)
			begin
				model_valid[s][w] = 1'b0;
				model_tag[s][w] = '0;
			end
		end
		repeat (2) @(posedge clk);
		#2;
		reset = 1'b0;

		// Empty cache misses everywhere
		for (int i = 0; i < 8; i++)
			lookup_expect(line_addr(32'h0a5a5 + i * 3, i * 2), 1'b0);

		// First fill of a set lands in way 0
		install_line(line_addr(32'h1234, 3));
		lookup_expect(line_addr(32'h1234, 3), 1'b1);

		// Fill set 5 completely, then hit ways in the order 0 2 3 1.
		// The fill right after the way 1 hit drops that touch, so way 1 is evicted
		for (int i = 0; i < 4; i++)
			install_line(line_addr(32'h100 + i, 5));
		lookup_expect(line_addr(32'h100, 5), 1'b1);
		lookup_expect(line_addr(32'h102, 5), 1'b1);
		lookup_expect(line_addr(32'h103, 5), 1'b1);
		lookup_expect(line_addr(32'h101, 5), 1'b1);
		install_line(line_addr(32'h104, 5));
		lookup_expect(line_addr(32'h101, 5), 1'b0);
		lookup_expect(line_addr(32'h100, 5), 1'b1);
		lookup_expect(line_addr(32'h102, 5), 1'b1);
		lookup_expect(line_addr(32'h103, 5), 1'b1);
		lookup_expect(line_addr(32'h104, 5), 1'b1);

		// Invalidate a present line, then an absent one
		invalidate_line(line_addr(32'h102, 5));
		lookup_expect(line_addr(32'h102, 5), 1'b0);
		lookup_expect(line_addr(32'h100, 5), 1'b1);
		lookup_expect(line_addr(32'h103, 5), 1'b1);
		invalidate_line(line_addr(32'h3ff, 5));
		lookup_expect(line_addr(32'h104, 5), 1'b1);
		lookup_expect(line_addr(32'h100, 5), 1'b1);

		// Flush set 5 while set 7 and set 3 keep their lines
		install_line(line_addr(32'h200, 7));
		install_line(line_addr(32'h201, 7));
		flush_one_set(5);
		lookup_expect(line_addr(32'h100, 5), 1'b0);
		lookup_expect(line_addr(32'h103, 5), 1'b0);
		lookup_expect(line_addr(32'h104, 5), 1'b0);
		lookup_expect(line_addr(32'h200, 7), 1'b1);
		lookup_expect(line_addr(32'h201, 7), 1'b1);
		lookup_expect(line_addr(32'h1234, 3), 1'b1);

		// Random legal traffic; a fill of a present line turns into a lookup
		for (int i = 0; i < random_cycles; i++)
		begin
			pick = int'($unsigned($random(seed)) % 16);
			rand_addr = random_addr();
			if (pick < 6)
				send_lookup(rand_addr);
			else if (pick < 11)
			begin
				if (find_way(rand_addr) < 0)
					install_line(rand_addr);
				else
					send_lookup(rand_addr);
			end
			else if (pick < 14)
				invalidate_line(rand_addr);
			else if (pick == 14)
				flush_one_set(set_of(rand_addr));
			else
				idle_cycle();
		end

		// Let the last response be compared
		idle_cycle();
		idle_cycle();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

/* all.f */
cache_pkg.sv
sram_1r1w.sv
cache_valid_array.sv
l1_cache_tag.sv
cache_lru.sv
cache_tag_ctrl.sv
l1_tag_unit.sv
tb_l1_tag_unit.sv

/* run.sh */
#!/bin/sh
# Builds the L1 tag unit testbench with Verilator and runs it.
# The run passes only if the pass message shows up in sim.log.
set -e

cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f all.f \
	--top-module tb_l1_tag_unit -o sim_tb_l1_tag_unit
./obj_dir/sim_tb_l1_tag_unit 2>&1 | tee sim.log

if grep -qx "ALL CHECKS PASSED" sim.log; then
	exit 0
fi
exit 1
